// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = elink_tx_tb
FILELIST  = elink_tx.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_TEXT = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

# Build the simulation binary
compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the run printed the pass line
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/elink_tx.sv ====
module elink_tx (
   input  logic                     txo_lclk,
   input  logic                     reset,
   input  logic                     link_enable,
   input  logic                     invert,
   input  elink_tx_pkg::tx_word_t   tx_word,
   output logic                     word_take,
   output elink_tx_pkg::ddr_pair_t  lane_bits,
   output logic [8:0]               lane_oe,
   output elink_tx_pkg::lclk_pair_t lclk_out
);

   // Word slot position
   elink_tx_pkg::phase_t phase;

   // Link running flag from the FSM
   logic link_on;

   //##############################
   // Timing
   //##############################

   elink_tx_phase_counter i_phase_counter (
      .txo_lclk  (txo_lclk),
      .reset     (reset),
      .phase     (phase),
      .word_take (word_take)
   );

   elink_tx_link_fsm i_link_fsm (
      .txo_lclk    (txo_lclk),
      .reset       (reset),
      .link_enable (link_enable),
      .word_take   (word_take),
      .link_on     (link_on)
   );

   //##############################
   // Data and pins
   //##############################

   elink_tx_serializer i_serializer (
      .txo_lclk  (txo_lclk),
      .reset     (reset),
      .word_take (word_take),
      .phase     (phase),
      .invert    (invert),
      .tx_word   (tx_word),
      .lane_bits (lane_bits)
   );

   elink_tx_output_stage i_output_stage (
      .txo_lclk (txo_lclk),
      .reset    (reset),
      .link_on  (link_on),
      .invert   (invert),
      .lane_oe  (lane_oe),
      .lclk_out (lclk_out)
   );

endmodule

// ==== design/elink_tx_link_fsm.sv ====
module elink_tx_link_fsm (
   input  logic txo_lclk,
   input  logic reset,
   input  logic link_enable,
   input  logic word_take,
   output logic link_on
);

   elink_tx_pkg::link_state_t state;
   elink_tx_pkg::link_state_t state_next;

   //##############################
   // Next state
   //##############################

   always_comb begin
      state_next = state;
      case (state)
         // Idle until the device asks for the link
         elink_tx_pkg::LINK_OFF: begin
            if (link_enable) begin
               state_next = elink_tx_pkg::LINK_ARM;
            end
         end
         // Wait for a word boundary
         // Give up if the request goes away first
         elink_tx_pkg::LINK_ARM: begin
            if (!link_enable) begin
               state_next = elink_tx_pkg::LINK_OFF;
            end else if (word_take) begin
               state_next = elink_tx_pkg::LINK_ON;
            end
         end
         // Running
         elink_tx_pkg::LINK_ON: begin
            if (!link_enable) begin
               state_next = elink_tx_pkg::LINK_DRAIN;
            end
         end
         // Word in flight still going out
         // Stop at the next boundary
         elink_tx_pkg::LINK_DRAIN: begin
            if (word_take) begin
               state_next = elink_tx_pkg::LINK_OFF;
            end
         end
         default: begin
            state_next = elink_tx_pkg::LINK_OFF;
         end
      endcase
   end

   //##############################
   // State and link flag
   //##############################

   // Flag follows the next state
   // so it rises or falls one cycle after a take cycle
   always_ff @(posedge txo_lclk) begin
      if (reset) begin
         state   <= elink_tx_pkg::LINK_OFF;
         link_on <= 1'b0;
      end else begin
         state   <= state_next;
         link_on <= (state_next == elink_tx_pkg::LINK_ON) ||
                    (state_next == elink_tx_pkg::LINK_DRAIN);
      end
   end

endmodule

// ==== design/elink_tx_macros.svh ====
`ifndef ELINK_TX_MACROS_SVH
`define ELINK_TX_MACROS_SVH

//##############################
// Link geometry
//##############################

// Eight data lanes plus the frame lane
`define ELINK_LANES 9

// One byte per lane per word
`define ELINK_LANE_BITS 8

//##############################
// Serialization cadence
//##############################

// Fast clock cycles per device word
`define ELINK_PHASES 4

`endif

// ==== design/elink_tx_output_stage.sv ====
`include "elink_tx_macros.svh"

module elink_tx_output_stage (
   input  logic                     txo_lclk,
   input  logic                     reset,
   input  logic                     link_on,
   input  logic                     invert,
   output logic [`ELINK_LANES-1:0]  lane_oe,
   output elink_tx_pkg::lclk_pair_t lclk_out
);

   //##############################
   // Lane enables
   //##############################

   // One flop of delay lines link_on up with the pair register
   // Enables switch on the first phase-0 pair of a word
   // Frame lane never tristates
   always_ff @(posedge txo_lclk) begin
      if (reset) begin
         lane_oe <= {1'b1, {(`ELINK_LANES-1){1'b0}}};
      end else begin
         lane_oe <= {1'b1, {(`ELINK_LANES-1){link_on}}};
      end
   end

   //##############################
   // Forwarded clock pattern
   //##############################

   // Same delay as the enables
   // Normal polarity drives high on the rising half
   // Inverted link swaps the halves
   // Held low while the link is off
   always_ff @(posedge txo_lclk) begin
      if (reset) begin
         lclk_out <= '0;
      end else begin
         lclk_out.rise <= link_on & ~invert;
         lclk_out.fall <= link_on & invert;
      end
   end

   // Pads sample this pair with the quarter-cycle
   // shifted clock in the later pad layer

endmodule

// ==== design/elink_tx_phase_counter.sv ====
module elink_tx_phase_counter (
   input  logic                 txo_lclk,
   input  logic                 reset,
   output elink_tx_pkg::phase_t phase,
   output logic                 word_take
);

   //##############################
   // Word slot counter
   //##############################

   // Stands in for slow clock edge detection
   // Phase 0 is the first cycle after reset
   // Wraps every four cycles
   always_ff @(posedge txo_lclk) begin
      if (reset) begin
         phase <= '0;
      end else begin
         phase <= phase + 2'd1;
      end
   end

   //##############################
   // Word take strobe
   //##############################

   // Decoded one cycle early
   // so the strobe is high exactly in phase 3
   // Device word sampled at the end of that cycle
   always_ff @(posedge txo_lclk) begin
      if (reset) begin
         word_take <= 1'b0;
      end else begin
         word_take <= (phase == 2'd2);
      end
   end

   // Capture and bit selection stay a fixed
   // distance apart because both key off this strobe
   // and the same phase count

endmodule

// ==== design/elink_tx_pkg.sv ====
`include "elink_tx_macros.svh"

package elink_tx_pkg;

   //##############################
   // Device word
   //##############################

   // One byte per lane
   // Lane L sits in bits 8L+7 down to 8L
   // Top lane is the frame lane
   typedef logic [`ELINK_LANES-1:0][`ELINK_LANE_BITS-1:0] tx_word_t;

   //##############################
   // Pin side pairs
   //##############################

   // Bit pair per lane for one fast cycle
   // Even goes out on the rising half
   // Odd goes out on the falling half
   typedef struct packed {
      logic [`ELINK_LANES-1:0] even;
      logic [`ELINK_LANES-1:0] odd;
   } ddr_pair_t;

   // Forwarded clock level per half cycle
   typedef struct packed {
      logic rise;
      logic fall;
   } lclk_pair_t;

   //##############################
   // Control
   //##############################

   // Position inside the four-cycle word slot
   typedef logic [$clog2(`ELINK_PHASES)-1:0] phase_t;

   // Link on/off sequencing
   typedef enum logic [1:0] {
      LINK_OFF,
      LINK_ARM,
      LINK_ON,
      LINK_DRAIN
   } link_state_t;

endpackage

// ==== design/elink_tx_serializer.sv ====
`include "elink_tx_macros.svh"

module elink_tx_serializer (
   input  logic                    txo_lclk,
   input  logic                    reset,
   input  logic                    word_take,
   input  elink_tx_pkg::phase_t    phase,
   input  logic                    invert,
   input  elink_tx_pkg::tx_word_t  tx_word,
   output elink_tx_pkg::ddr_pair_t lane_bits
);

   // Word being sent
   elink_tx_pkg::tx_word_t word_q;

   // Pair for the current phase before the output flop
   elink_tx_pkg::ddr_pair_t pair_next;

   //##############################
   // Word capture
   //##############################

   // Sampled at the end of the take cycle
   // Polarity fixed here so later stages never see it
   // Holds through the next four phases
   always_ff @(posedge txo_lclk) begin
      if (word_take) begin
         if (invert) begin
            word_q <= ~tx_word;
         end else begin
            word_q <= tx_word;
         end
      end
   end

   //##############################
   // Channel to byte alignment
   //##############################

   // Phase 0 follows the take cycle directly
   // so the counter value picks the pair
   // Most significant bit first
   // Phase k sends bits 7-2k and 6-2k of every lane
   always_comb begin
      int hi_bit;
      hi_bit    = `ELINK_LANE_BITS - 1 - 2 * int'(phase);
      pair_next = '0;
      for (int lane = 0; lane < `ELINK_LANES; lane++) begin
         // Rising half carries the higher bit
         pair_next.even[lane] = word_q[lane][hi_bit];
         // Falling half carries the next one down
         pair_next.odd[lane]  = word_q[lane][hi_bit-1];
      end
   end

   //##############################
   // Pair register
   //##############################

   // Pair for phase k of a word taken in cycle T
   // shows up in cycle T+2+k
   // Next word is captured while this one drains
   always_ff @(posedge txo_lclk) begin
      if (reset) begin
         lane_bits <= '0;
      end else begin
         lane_bits <= pair_next;
      end
   end

   // Frame lane rides in the top byte
   // and is serialized exactly like data

endmodule

// ==== elink_tx.f ====
+incdir+design
design/elink_tx_pkg.sv
design/elink_tx_phase_counter.sv
design/elink_tx_link_fsm.sv
design/elink_tx_serializer.sv
design/elink_tx_output_stage.sv
design/elink_tx.sv
testbench/elink_tx_tb.sv

// ==== testbench/elink_tx_tb.sv ====
`include "elink_tx_macros.svh"

module elink_tx_tb;

   //##############################
   // Run length
   //##############################

   localparam int RESET_CYCLES   = 10;
   // Words taken by the stimulus sequence
   localparam int N_WORDS        = 44;
   localparam int TIMEOUT_CYCLES = 4 * N_WORDS + RESET_CYCLES + 50;

   //##############################
   // DUT signals
   //##############################

   logic                     txo_lclk = 1'b0;
   logic                     reset;
   logic                     link_enable;
   logic                     invert;
   elink_tx_pkg::tx_word_t   tx_word;
   logic                     word_take;
   elink_tx_pkg::ddr_pair_t  lane_bits;
   logic [`ELINK_LANES-1:0]  lane_oe;
   elink_tx_pkg::lclk_pair_t lclk_out;

   // Random stream state
   integer seed;

   // Cycle counter for the timeout
   int cycle_count = 0;

   //##############################
   // Reference model state
   //##############################

   elink_tx_pkg::phase_t        m_phase = '0;
   logic                        m_take = 1'b0;
   logic                        m_reset_seen = 1'b1;
   elink_tx_pkg::link_state_t   m_state = elink_tx_pkg::LINK_OFF;
   logic                        m_link_on = 1'b0;
   logic                        m_oe_on = 1'b0;
   logic                        m_inv_q = 1'b0;
   elink_tx_pkg::tx_word_t      word_q[$];
   elink_tx_pkg::tx_word_t      cur_word = '0;
   logic                        cur_valid = 1'b0;

   // Coverage of the interesting cases
   int pairs_checked = 0;
   int on_normal     = 0;
   int on_inverted   = 0;

   // Cadence and enable alignment tracking
   int                      cycles_since_take = 0;
   logic                    take_seen = 1'b0;
   logic [`ELINK_LANES-2:0] prev_oe_data = '0;

   elink_tx i_dut (
      .txo_lclk    (txo_lclk),
      .reset       (reset),
      .link_enable (link_enable),
      .invert      (invert),
      .tx_word     (tx_word),
      .word_take   (word_take),
      .lane_bits   (lane_bits),
      .lane_oe     (lane_oe),
      .lclk_out    (lclk_out)
   );

   always #4 txo_lclk = ~txo_lclk;

   //##############################
   // Helpers
   //##############################

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic report_mismatch(input string name, input logic [71:0] expected,
                                  input logic [71:0] actual);
      stop_with_failure($sformatf("Fail %s expected 0x%0h actual 0x%0h",
                                  name, expected, actual));
   endtask

   // 72 random bits from three draws
   function automatic elink_tx_pkg::tx_word_t random_word();
      logic [95:0] r;
      r = {$random(seed), $random(seed), $random(seed)};
      return r[71:0];
   endfunction

   // Byte shifted left so the pair for phase k lands in bits 7 and 6
   function automatic elink_tx_pkg::ddr_pair_t expected_pair(
         input elink_tx_pkg::tx_word_t w, input elink_tx_pkg::phase_t k);
      elink_tx_pkg::ddr_pair_t p;
      logic [`ELINK_LANE_BITS-1:0] lane_byte;
      p = '0;
      for (int lane = 0; lane < `ELINK_LANES; lane++) begin
         lane_byte     = w[lane] << {k, 1'b0};
         p.even[lane]  = lane_byte[7];
         p.odd[lane]   = lane_byte[6];
      end
      return p;
   endfunction

   // Waits for each take and presents the next word
   task automatic run_words(input int count);
      for (int i = 0; i < count; i++) begin
         do @(negedge txo_lclk); while (word_take !== 1'b1);
         @(posedge txo_lclk);
         tx_word <= random_word();
      end
   endtask

   //##############################
   // Reference model
   //##############################

   // Steps once per rising edge on the same inputs the DUT samples
   always @(posedge txo_lclk) begin
      m_reset_seen = reset;
      if (reset) begin
         m_phase   = '0;
         m_take    = 1'b0;
         m_state   = elink_tx_pkg::LINK_OFF;
         m_link_on = 1'b0;
         m_oe_on   = 1'b0;
         m_inv_q   = 1'b0;
         cur_valid = 1'b0;
         word_q.delete();
      end else begin
         // Pins follow the link flag one cycle later
         m_oe_on = m_link_on;
         m_inv_q = invert;
         case (m_state)
            elink_tx_pkg::LINK_OFF:
               if (link_enable) m_state = elink_tx_pkg::LINK_ARM;
            elink_tx_pkg::LINK_ARM:
               if (!link_enable) m_state = elink_tx_pkg::LINK_OFF;
               else if (m_take) m_state = elink_tx_pkg::LINK_ON;
            elink_tx_pkg::LINK_ON:
               if (!link_enable) m_state = elink_tx_pkg::LINK_DRAIN;
            default:
               if (m_take) m_state = elink_tx_pkg::LINK_OFF;
         endcase
         m_link_on = (m_state == elink_tx_pkg::LINK_ON) ||
                     (m_state == elink_tx_pkg::LINK_DRAIN);
         // Word taken at the end of the take cycle
         if (m_take) begin
            word_q.push_back(invert ? ~tx_word : tx_word);
         end
         m_phase = m_phase + 2'd1;
         m_take  = (m_phase == 2'd3);
         // Phase 0 pair of a word shows in the second cycle after its take
         if (m_phase == 2'd1 && word_q.size() > 0) begin
            cur_word  = word_q.pop_front();
            cur_valid = 1'b1;
         end
      end
   end

   //##############################
   // Output checks
   //##############################

   // Sampled on the falling edge once outputs settle
   always @(negedge txo_lclk) begin
      elink_tx_pkg::ddr_pair_t  exp_pair;
      elink_tx_pkg::lclk_pair_t exp_lclk;
      logic [`ELINK_LANES-1:0]  exp_oe;
      exp_oe        = {1'b1, {(`ELINK_LANES-1){m_oe_on}}};
      exp_lclk.rise = m_oe_on & ~m_inv_q;
      exp_lclk.fall = m_oe_on & m_inv_q;
      assert (word_take === m_take)
         else report_mismatch("word_take", 72'(m_take), 72'(word_take));
      assert (lane_oe === exp_oe)
         else report_mismatch("lane_oe", 72'(exp_oe), 72'(lane_oe));
      assert (lclk_out === exp_lclk)
         else report_mismatch("lclk_out", 72'(exp_lclk), 72'(lclk_out));
      if (m_reset_seen) begin
         assert (lane_bits === '0)
            else report_mismatch("lane_bits", 72'(0), 72'(lane_bits));
      end else if (cur_valid) begin
         // Current phase k is one behind the model counter
         exp_pair = expected_pair(cur_word, m_phase + 2'd3);
         assert (lane_bits === exp_pair)
            else report_mismatch("lane_bits", 72'(exp_pair), 72'(lane_bits));
         pairs_checked++;
      end
      if (lclk_out.rise === 1'b1) on_normal++;
      if (lclk_out.fall === 1'b1) on_inverted++;
   end

   // Strobe spacing and enable alignment independent of the model flags
   always @(negedge txo_lclk) begin
      if (!m_reset_seen) begin
         cycles_since_take++;
         if (word_take === 1'b1) begin
            if (take_seen) begin
               assert (cycles_since_take == 4)
                  else stop_with_failure("word_take is not spaced four cycles apart");
            end
            take_seen         = 1'b1;
            cycles_since_take = 0;
         end
         // Only the phase-0 pair may carry an enable change
         if (lane_oe[`ELINK_LANES-2:0] !== prev_oe_data) begin
            assert (m_phase == 2'd1)
               else stop_with_failure("lane enables changed away from a phase-0 pair");
         end
         prev_oe_data = lane_oe[`ELINK_LANES-2:0];
      end
   end

   //##############################
   // Timeout
   //##############################

   always @(posedge txo_lclk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         stop_with_failure("timeout before all tests finished");
      end
   end

   //##############################
   // Stimulus
   //##############################

   initial begin
      seed = 51420;
      reset       <= 1'b1;
      link_enable <= 1'b0;
      invert      <= 1'b0;
      tx_word     <= random_word();
      repeat (RESET_CYCLES) @(posedge txo_lclk);
      reset <= 1'b0;
      // Link off with data still serialized
      run_words(4);
      link_enable <= 1'b1;
      run_words(12);
      // Word in flight drains and the link stops at a boundary
      link_enable <= 1'b0;
      run_words(6);
      // Inverted link
      invert <= 1'b1;
      run_words(2);
      link_enable <= 1'b1;
      run_words(12);
      link_enable <= 1'b0;
      run_words(6);
      invert <= 1'b0;
      run_words(2);
      // Let the last words leave the pipeline
      repeat (8) @(posedge txo_lclk);
      if (pairs_checked >= 150 && on_normal > 0 && on_inverted > 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         stop_with_failure("stimulus did not reach every link mode");
      end
   end

endmodule
